//--- rtl/dec_config.svh
/*
 * decode pipeline sizing defines: data width, register count, buffer depth
 */

`ifndef DEC_CONFIG_SVH
`define DEC_CONFIG_SVH

// ******************************
// datapath
// ******************************
`define DEC_XLEN 32           // integer register and ALU width
`define DEC_NUM_GPR 32        // architectural registers, x0 included

// ******************************
// instruction buffer
// ******************************
`define DEC_IB_DEPTH 4        // fetch entries held ahead of decode

`endif

//--- rtl/rv_isa_pkg.sv
/*
 * RV32I encoding types used by decode and execute
 * major opcodes, ALU operations, register index
 */

`default_nettype none

`include "dec_config.svh"

package rv_isa_pkg;

   // ******************************
   // major opcode, instr[6:0]
   // ******************************
   typedef enum logic [6:0] {
      OP     = 7'b0110011,                    // reg-reg ALU
      OP_IMM = 7'b0010011,                    // reg-imm ALU
      LUI    = 7'b0110111                     // load upper immediate
   } opcode_e;

   // ******************************
   // ALU operation select
   // ******************************
   typedef enum logic [3:0] {
      ADD    = 4'd0,
      SUB    = 4'd1,
      AND    = 4'd2,
      OR     = 4'd3,
      XOR    = 4'd4,
      SLT    = 4'd5,                          // signed compare
      SLL    = 4'd6,
      SRL    = 4'd7,
      PASS_B = 4'd8                           // operand b straight through, LUI
   } alu_op_e;

   // gpr index, sized from the register count
   typedef logic [$clog2(`DEC_NUM_GPR)-1:0] reg_idx_t;

endpackage

`default_nettype wire

//--- rtl/dec_pipe_pkg.sv
/*
 * pipeline packets: fetch entry, execute stage, writeback trace
 */

`default_nettype none

`include "dec_config.svh"

package dec_pipe_pkg;

   // fetch side entry, also the buffer payload
   typedef struct packed {
      logic [31:0] instr;                     // raw 32b instruction
      logic [31:1] pc;                        // halfword aligned pc
   } fetch_pkt_t;

   // ******************************
   // decode -> execute
   // ******************************
   typedef struct packed {
      logic                  valid;           // slot holds an instruction
      rv_isa_pkg::alu_op_e   alu_op;
      logic [`DEC_XLEN-1:0]  opa;             // bypass resolved rs1
      logic [`DEC_XLEN-1:0]  opb;             // rs2 or immediate
      rv_isa_pkg::reg_idx_t  rd;
      logic                  wen;             // result goes to rd
      logic                  illegal;         // unsupported encoding
      logic [31:0]           instr;
      logic [31:1]           pc;
   } exe_pkt_t;

   // ******************************
   // execute -> writeback / trace
   // ******************************
   typedef struct packed {
      logic                  valid;           // retiring this cycle
      logic                  exception;       // illegal instruction
      logic [31:0]           instr;
      logic [31:1]           pc;
      rv_isa_pkg::reg_idx_t  rd;
      logic [`DEC_XLEN-1:0]  wdata;           // zero on exception
   } trace_pkt_t;

endpackage

`default_nettype wire

//--- rtl/dec_ib_ctl.sv
/*
 * instruction buffer: circular FIFO between fetch and decode
 */

`timescale 1ns/10ps
`default_nettype none

`include "dec_config.svh"

module dec_ib_ctl (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    fetch_valid,   // fetch has an entry
   input  dec_pipe_pkg::fetch_pkt_t fetch_pkt,
   input  logic                    ib_take,       // decode consumes head
   output logic                    fetch_ready,   // room for one more
   output logic                    ib_valid,      // head entry present
   output dec_pipe_pkg::fetch_pkt_t ib_pkt
);

   localparam int PTR_W = (`DEC_IB_DEPTH > 1) ? $clog2(`DEC_IB_DEPTH) : 1;
   localparam int CNT_W = $clog2(`DEC_IB_DEPTH + 1);

   dec_pipe_pkg::fetch_pkt_t ib_mem [`DEC_IB_DEPTH];   // payload, no reset
   logic [PTR_W-1:0]         wr_ptr;
   logic [PTR_W-1:0]         rd_ptr;
   logic [CNT_W-1:0]         count;
   logic                     push;
   logic                     pop;

   assign fetch_ready = (count != CNT_W'(`DEC_IB_DEPTH));   // full holds fetch off
   assign ib_valid    = (count != '0);
   assign ib_pkt      = ib_mem[rd_ptr];                     // head visible same cycle
   assign push        = fetch_valid & fetch_ready;
   assign pop         = ib_take & ib_valid;

   always_ff @(posedge clk) begin
      if (push) begin
         ib_mem[wr_ptr] <= fetch_pkt;
      end
   end

   // ******************************
   // pointers and occupancy
   // ******************************
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(`DEC_IB_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;   // wrap
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(`DEC_IB_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;                         // idle or push+pop
         endcase
      end
   end

   // a refused entry must wait unchanged, otherwise a push while full is lost
   a_fetch_hold: assert property (@(posedge clk) disable iff (rst)
      fetch_valid && !fetch_ready |=> fetch_valid && $stable(fetch_pkt));

   // decode never takes from an empty buffer
   a_take_valid: assert property (@(posedge clk) disable iff (rst)
      ib_take |-> ib_valid);

endmodule

`default_nettype wire

//--- rtl/dec_decode_ctl.sv
/*
 * decode stage: RV32I OP/OP-IMM/LUI decode, immediates, illegal check,
 * operand bypass, halt tracking and the execute stage register
 */

`timescale 1ns/10ps
`default_nettype none

`include "dec_config.svh"

module dec_decode_ctl (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     ib_valid,
   input  dec_pipe_pkg::fetch_pkt_t ib_pkt,
   input  logic                     halt_req,    // stop taking new work
   input  logic [`DEC_XLEN-1:0]     rs1_data,    // gpr read port 0
   input  logic [`DEC_XLEN-1:0]     rs2_data,    // gpr read port 1
   input  dec_pipe_pkg::trace_pkt_t exe_fwd,     // execute result, 1st priority
   input  dec_pipe_pkg::trace_pkt_t wb_fwd,      // writeback result
   output logic                     ib_take,
   output rv_isa_pkg::reg_idx_t     rs1_addr,
   output rv_isa_pkg::reg_idx_t     rs2_addr,
   output dec_pipe_pkg::exe_pkt_t   exe,
   output logic                     halted       // pipe drained under halt
);

   logic [31:0]           instr;
   logic [6:0]            funct7;
   logic [2:0]            funct3;
   logic [`DEC_XLEN-1:0]  imm_i;
   logic [`DEC_XLEN-1:0]  imm_u;
   logic [`DEC_XLEN-1:0]  imm;
   logic [`DEC_XLEN-1:0]  rs1_val;
   logic [`DEC_XLEN-1:0]  rs2_val;
   logic                  use_imm;
   logic                  illegal;
   rv_isa_pkg::alu_op_e   alu_op;
   dec_pipe_pkg::exe_pkt_t exe_d;

   // youngest matching producer wins, x0 never bypasses
   function automatic logic [`DEC_XLEN-1:0] byp_sel(
      input rv_isa_pkg::reg_idx_t     src,
      input logic [`DEC_XLEN-1:0]     gpr_val,
      input dec_pipe_pkg::trace_pkt_t e_src,
      input dec_pipe_pkg::trace_pkt_t w_src
   );
      logic e_hit;
      logic w_hit;
      e_hit = e_src.valid && !e_src.exception && (e_src.rd == src) && (src != '0);
      w_hit = w_src.valid && !w_src.exception && (w_src.rd == src) && (src != '0);
      if (e_hit) return e_src.wdata;
      else if (w_hit) return w_src.wdata;
      else return gpr_val;
   endfunction

   assign instr    = ib_pkt.instr;
   assign funct7   = instr[31:25];
   assign funct3   = instr[14:12];
   assign rs1_addr = rv_isa_pkg::reg_idx_t'(instr[19:15]);
   assign rs2_addr = rv_isa_pkg::reg_idx_t'(instr[24:20]);
   assign ib_take  = ib_valid & ~halt_req;                       // halt stalls decode

   assign imm_i = {{(`DEC_XLEN-12){instr[31]}}, instr[31:20]};   // sign extended
   assign imm_u = {instr[31:12], 12'b0};

   // ******************************
   // opcode / funct decode
   // ******************************
   always_comb begin
      alu_op  = rv_isa_pkg::ADD;
      use_imm = 1'b0;
      imm     = imm_i;
      illegal = 1'b0;
      case (rv_isa_pkg::opcode_e'(instr[6:0]))
         rv_isa_pkg::OP: begin
            case ({funct7, funct3})
               10'b0000000_000: alu_op = rv_isa_pkg::ADD;
               10'b0100000_000: alu_op = rv_isa_pkg::SUB;
               10'b0000000_001: alu_op = rv_isa_pkg::SLL;
               10'b0000000_010: alu_op = rv_isa_pkg::SLT;
               10'b0000000_100: alu_op = rv_isa_pkg::XOR;
               10'b0000000_101: alu_op = rv_isa_pkg::SRL;
               10'b0000000_110: alu_op = rv_isa_pkg::OR;
               10'b0000000_111: alu_op = rv_isa_pkg::AND;
               default:         illegal = 1'b1;          // sltu, sra, M ext
            endcase
         end
         rv_isa_pkg::OP_IMM: begin
            use_imm = 1'b1;
            case (funct3)
               3'b000:  alu_op = rv_isa_pkg::ADD;
               3'b010:  alu_op = rv_isa_pkg::SLT;
               3'b100:  alu_op = rv_isa_pkg::XOR;
               3'b110:  alu_op = rv_isa_pkg::OR;
               3'b111:  alu_op = rv_isa_pkg::AND;
               3'b001: begin
                  alu_op  = rv_isa_pkg::SLL;
                  illegal = (funct7 != 7'b0);            // shamt[5] or srai style
               end
               3'b101: begin
                  alu_op  = rv_isa_pkg::SRL;
                  illegal = (funct7 != 7'b0);            // srai not supported
               end
               default: illegal = 1'b1;                  // sltiu
            endcase
         end
         rv_isa_pkg::LUI: begin
            alu_op  = rv_isa_pkg::PASS_B;
            use_imm = 1'b1;
            imm     = imm_u;
         end
         default: illegal = 1'b1;                        // loads, branches, system...
      endcase
   end

   assign rs1_val = byp_sel(rs1_addr, rs1_data, exe_fwd, wb_fwd);
   assign rs2_val = byp_sel(rs2_addr, rs2_data, exe_fwd, wb_fwd);

   always_comb begin
      exe_d.valid   = ib_take;                           // bubble when nothing taken
      exe_d.alu_op  = alu_op;
      exe_d.opa     = rs1_val;
      exe_d.opb     = use_imm ? imm : rs2_val;
      exe_d.rd      = rv_isa_pkg::reg_idx_t'(instr[11:7]);
      exe_d.wen     = ib_take & ~illegal;                // illegal kills the write
      exe_d.illegal = ib_take & illegal;
      exe_d.instr   = instr;
      exe_d.pc      = ib_pkt.pc;
   end

   // ******************************
   // execute register, halt status
   // ******************************
   always_ff @(posedge clk) begin
      if (rst) begin
         exe.valid   <= 1'b0;
         exe.wen     <= 1'b0;
         exe.illegal <= 1'b0;
         halted      <= 1'b0;
      end else begin
         exe    <= exe_d;
         halted <= halt_req & ~exe.valid & ~wb_fwd.valid;   // drained under halt
      end
   end

   // a register write only ever comes from a kept major opcode
   a_illegal_no_wen: assert property (@(posedge clk) disable iff (rst)
      exe.wen |-> !exe.illegal && (exe.instr[6:0] inside {rv_isa_pkg::OP,
                                                          rv_isa_pkg::OP_IMM,
                                                          rv_isa_pkg::LUI}));

endmodule

`default_nettype wire

//--- rtl/dec_gpr_ctl.sv
/*
 * integer register file, two combinational reads, one write
 */

`timescale 1ns/10ps
`default_nettype none

`include "dec_config.svh"

module dec_gpr_ctl (
   input  logic                     clk,
   input  logic                     rst,
   input  rv_isa_pkg::reg_idx_t     rs1_addr,
   input  rv_isa_pkg::reg_idx_t     rs2_addr,
   input  dec_pipe_pkg::trace_pkt_t wb,        // writeback packet
   output logic [`DEC_XLEN-1:0]     rs1_data,
   output logic [`DEC_XLEN-1:0]     rs2_data
);

   logic [`DEC_XLEN-1:0] gpr [`DEC_NUM_GPR];
   logic                 wr_en;

   // retire with no exception, x0 discarded
   assign wr_en = wb.valid & ~wb.exception & (wb.rd != '0);

   always_ff @(posedge clk) begin
      if (rst) begin
         gpr[0] <= '0;                                 // x0 pinned at zero
      end else if (wr_en) begin
         gpr[wb.rd] <= wb.wdata;                       // lands at end of wb cycle
      end
   end

   assign rs1_data = gpr[rs1_addr];
   assign rs2_data = gpr[rs2_addr];

   // a retiring write aimed at x0 must leave it zero
   a_x0_zero: assert property (@(posedge clk) disable iff (rst)
      wb.valid && (wb.rd == '0) |=> (gpr[0] == '0));

endmodule

`default_nettype wire

//--- rtl/dec_exu_ctl.sv
/*
 * execute stage ALU and the writeback register feeding gpr, bypass and trace
 */

`timescale 1ns/10ps
`default_nettype none

`include "dec_config.svh"

module dec_exu_ctl (
   input  logic                     clk,
   input  logic                     rst,
   input  dec_pipe_pkg::exe_pkt_t   exe,
   output dec_pipe_pkg::trace_pkt_t exe_fwd,   // combinational, execute bypass
   output dec_pipe_pkg::trace_pkt_t wb         // registered, writeback
);

   localparam int SHAMT_W = $clog2(`DEC_XLEN);

   logic [`DEC_XLEN-1:0] result;
   logic [SHAMT_W-1:0]   shamt;
   logic                 lt;

   assign shamt = exe.opb[SHAMT_W-1:0];               // low bits only
   assign lt    = $signed(exe.opa) < $signed(exe.opb);

   // ******************************
   // ALU
   // ******************************
   always_comb begin
      case (exe.alu_op)
         rv_isa_pkg::ADD:    result = exe.opa + exe.opb;
         rv_isa_pkg::SUB:    result = exe.opa - exe.opb;
         rv_isa_pkg::AND:    result = exe.opa & exe.opb;
         rv_isa_pkg::OR:     result = exe.opa | exe.opb;
         rv_isa_pkg::XOR:    result = exe.opa ^ exe.opb;
         rv_isa_pkg::SLT:    result = {{(`DEC_XLEN-1){1'b0}}, lt};
         rv_isa_pkg::SLL:    result = exe.opa << shamt;
         rv_isa_pkg::SRL:    result = exe.opa >> shamt;
         rv_isa_pkg::PASS_B: result = exe.opb;         // lui
         default:            result = '0;
      endcase
   end

   always_comb begin
      exe_fwd.valid     = exe.valid;
      exe_fwd.exception = exe.illegal;
      exe_fwd.instr     = exe.instr;
      exe_fwd.pc        = exe.pc;
      exe_fwd.rd        = exe.rd;
      exe_fwd.wdata     = exe.wen ? result : '0;      // zero for illegal
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wb.valid     <= 1'b0;
         wb.exception <= 1'b0;
      end else begin
         wb <= exe_fwd;                                // one cycle exe -> wb
      end
   end

endmodule

`default_nettype wire

//--- rtl/dec_top.sv
/*
 * decode pipeline top: buffer, decode, register file, execute
 */

`timescale 1ns/10ps
`default_nettype none

`include "dec_config.svh"

module dec_top (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     fetch_valid,
   input  dec_pipe_pkg::fetch_pkt_t fetch_pkt,
   input  logic                     halt_req,
   output logic                     fetch_ready,
   output dec_pipe_pkg::trace_pkt_t trace,       // retire stream, also gpr write
   output logic                     halted
);

   logic                     ib_valid;
   logic                     ib_take;
   dec_pipe_pkg::fetch_pkt_t ib_pkt;
   rv_isa_pkg::reg_idx_t     rs1_addr;
   rv_isa_pkg::reg_idx_t     rs2_addr;
   logic [`DEC_XLEN-1:0]     rs1_data;
   logic [`DEC_XLEN-1:0]     rs2_data;
   dec_pipe_pkg::exe_pkt_t   exe;
   dec_pipe_pkg::trace_pkt_t exe_fwd;

   dec_ib_ctl i_ib (
      .clk(clk), .rst(rst),
      .fetch_valid(fetch_valid), .fetch_pkt(fetch_pkt), .ib_take(ib_take),
      .fetch_ready(fetch_ready), .ib_valid(ib_valid), .ib_pkt(ib_pkt)
   );

   dec_decode_ctl i_decode (
      .clk(clk), .rst(rst),
      .ib_valid(ib_valid), .ib_pkt(ib_pkt), .halt_req(halt_req),
      .rs1_data(rs1_data), .rs2_data(rs2_data),
      .exe_fwd(exe_fwd), .wb_fwd(trace),                  // wb bypass is the trace
      .ib_take(ib_take), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
      .exe(exe), .halted(halted)
   );

   dec_gpr_ctl i_gpr (
      .clk(clk), .rst(rst),
      .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .wb(trace),
      .rs1_data(rs1_data), .rs2_data(rs2_data)
   );

   dec_exu_ctl i_exu (
      .clk(clk), .rst(rst),
      .exe(exe), .exe_fwd(exe_fwd), .wb(trace)
   );

endmodule

`default_nettype wire

//--- verification/dec_checker.sv
/*
 * trace checker: architectural register model, retire-order queue,
 * buffer occupancy and halt timing model
 */

`timescale 1ns/10ps
`default_nettype none

`include "dec_config.svh"

module dec_checker (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     fetch_valid,
   input  dec_pipe_pkg::fetch_pkt_t fetch_pkt,
   input  logic                     fetch_ready,
   input  logic                     halt_req,
   input  dec_pipe_pkg::trace_pkt_t trace,
   input  logic                     halted,
   output int                       errors,
   output int                       accepted,
   output int                       retired
);

   dec_pipe_pkg::fetch_pkt_t pend_q [$];         // accepted, not yet retired
   logic [`DEC_XLEN-1:0]     regs [`DEC_NUM_GPR]; // architectural state
   dec_pipe_pkg::fetch_pkt_t p;
   logic [`DEC_XLEN-1:0]     res;
   logic                     exc;
   logic                     take;
   logic                     accept;
   logic                     exe_v;               // modeled execute slot
   logic                     wb_v;                // modeled writeback slot
   logic                     halted_m;
   int                       occ;                 // modeled buffer fill
   int                       err_cnt = 0;
   int                       acc_cnt = 0;
   int                       ret_cnt = 0;

   assign errors   = err_cnt;
   assign accepted = acc_cnt;
   assign retired  = ret_cnt;

   task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAIL %s: got %h expected %h", name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAIL %s: got %h expected %h", name, got, exp);
         err_cnt++;
      end
   endtask

   // ******************************
   // RV32I reference execution
   // ******************************
   task automatic run_model(input dec_pipe_pkg::fetch_pkt_t pkt, output logic x,
                            output logic [31:0] r);
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm;
      logic [4:0]  rd;
      a   = regs[pkt.instr[19:15]];
      b   = regs[pkt.instr[24:20]];
      imm = {{20{pkt.instr[31]}}, pkt.instr[31:20]};   // I-type, sign extended
      rd  = pkt.instr[11:7];
      x   = 1'b0;
      r   = '0;
      case (pkt.instr[6:0])
         7'b0110011: begin
            case ({pkt.instr[31:25], pkt.instr[14:12]})
               10'b0000000_000: r = a + b;
               10'b0100000_000: r = a - b;
               10'b0000000_001: r = a << b[4:0];
               10'b0000000_010: r = {31'b0, $signed(a) < $signed(b)};
               10'b0000000_100: r = a ^ b;
               10'b0000000_101: r = a >> b[4:0];
               10'b0000000_110: r = a | b;
               10'b0000000_111: r = a & b;
               default:         x = 1'b1;        // sltu, sra, mul...
            endcase
         end
         7'b0010011: begin
            case (pkt.instr[14:12])
               3'b000:  r = a + imm;
               3'b010:  r = {31'b0, $signed(a) < $signed(imm)};
               3'b100:  r = a ^ imm;
               3'b110:  r = a | imm;
               3'b111:  r = a & imm;
               3'b001:  r = a << pkt.instr[24:20];
               3'b101:  r = a >> pkt.instr[24:20];
               default: x = 1'b1;                // sltiu
            endcase
            if (pkt.instr[13:12] == 2'b01 && pkt.instr[31:25] != 7'b0) x = 1'b1;   // srai
         end
         7'b0110111: r = {pkt.instr[31:12], 12'b0};   // lui
         default:    x = 1'b1;
      endcase
      if (x) r = '0;                                  // no data on exception
      else if (rd != 5'd0) regs[rd] = r;
   endtask

   // sampled at the rising edge, inputs settled since the falling edge
   always @(posedge clk) begin
      if (rst) begin
         occ      = 0;
         exe_v    = 1'b0;
         wb_v     = 1'b0;
         halted_m = 1'b0;
         regs[0]  = '0;
         pend_q.delete();
      end else begin
         check_bit("fetch_ready", fetch_ready, occ != `DEC_IB_DEPTH);
         check_bit("halted", halted, halted_m);
         check_bit("trace.valid", trace.valid, wb_v);   // accept N -> retire after N+2
         if (halted === 1'b1 && trace.valid === 1'b1) begin
            $display("trace entry retired while the pipeline reports halted");
            err_cnt++;
         end
         if (trace.valid === 1'b1) begin
            if (pend_q.size() == 0) begin
               $display("trace entry retired with no accepted instruction outstanding");
               err_cnt++;
            end else begin
               p = pend_q.pop_front();
               run_model(p, exc, res);
               check_bit("trace.exception", trace.exception, exc);
               check_word("trace.instr", trace.instr, p.instr);
               check_word("trace.pc", 32'(trace.pc), 32'(p.pc));
               check_word("trace.rd", 32'(trace.rd), 32'(p.instr[11:7]));
               check_word("trace.wdata", trace.wdata, res);
            end
            ret_cnt++;
         end
         accept = fetch_valid & fetch_ready;
         take   = (occ > 0) && !halt_req;               // decode takes unless halted
         if (accept) begin
            pend_q.push_back(fetch_pkt);
            acc_cnt++;
         end
         occ      = occ + (accept ? 1 : 0) - (take ? 1 : 0);
         halted_m = halt_req && !exe_v && !wb_v;
         wb_v     = exe_v;
         exe_v    = take;
      end
   end

endmodule

`default_nettype wire

//--- verification/dec_tb.sv
/*
 * testbench: clock and reset, LCG instruction stream, directed x0 and
 * illegal cases, halt sequencing, timeout and per-test reporting
 */

`timescale 1ns/10ps
`default_nettype none

`include "dec_config.svh"

module dec_tb;

   localparam int N_INIT    = 31;               // one addi per nonzero register
   localparam int N_RAND    = 200;
   localparam int N_DIRECT  = 11;               // x0 and illegal cases
   localparam int N_HALT    = `DEC_IB_DEPTH + 1;
   localparam int HALT_HOLD = 10;
   localparam int TIMEOUT_CYCLES = (N_INIT + N_RAND + N_DIRECT + N_HALT) * 4
                                   + 3 * HALT_HOLD + 100;

   logic                     clk;
   logic                     rst;
   logic                     fetch_valid;
   dec_pipe_pkg::fetch_pkt_t fetch_pkt;
   logic                     halt_req;
   logic                     fetch_ready;
   dec_pipe_pkg::trace_pkt_t trace;
   logic                     halted;
   int                       chk_errors;
   int                       accepted;
   int                       retired;
   int                       tb_errors;
   int                       err_mark;
   int                       tests_run;
   int                       tests_failed;
   int                       sent;
   int                       cycle_cnt = 0;
   logic [31:0]              lcg_state;
   logic [31:0]              pc;

   dec_top i_dec_top (
      .clk(clk), .rst(rst),
      .fetch_valid(fetch_valid), .fetch_pkt(fetch_pkt), .halt_req(halt_req),
      .fetch_ready(fetch_ready), .trace(trace), .halted(halted)
   );

   dec_checker i_checker (
      .clk(clk), .rst(rst),
      .fetch_valid(fetch_valid), .fetch_pkt(fetch_pkt), .fetch_ready(fetch_ready),
      .halt_req(halt_req), .trace(trace), .halted(halted),
      .errors(chk_errors), .accepted(accepted), .retired(retired)
   );

   always #20 clk = ~clk;                       // 40 ns period

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout: trace stalled");
         $display("FAIL: see errors above");
         $finish;
      end
   end

   // ******************************
   // stimulus helpers
   // ******************************
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [4:0] pick_reg();
      logic [31:0] r;
      r = lcg_next();
      return (r[31:29] == 3'd7) ? r[20:16] : {2'b00, r[18:16]};   // mostly x0..x7
   endfunction

   function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
      return {imm, rs1, f3, rd, 7'b0010011};
   endfunction

   function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
      return {imm, rd, 7'b0110111};
   endfunction

   function automatic logic [31:0] rand_instr();
      logic [31:0] r;
      logic [2:0]  f3;
      logic [11:0] imm;
      r  = lcg_next();
      f3 = r[2:0];
      if (r[31:28] <= 4'd6) begin                   // OP, f3 011 lands illegal
         return enc_r((f3 == 3'b000 && r[3]) ? 7'b0100000 : 7'b0000000,
                      pick_reg(), pick_reg(), f3, pick_reg());
      end else if (r[31:28] <= 4'd12) begin         // OP-IMM, sltiu lands illegal
         imm = (f3[1:0] == 2'b01) ? {7'b0, r[8:4]} : r[15:4];
         return enc_i(imm, pick_reg(), f3, pick_reg());
      end else if (r[31:28] <= 4'd14) begin
         return enc_u(r[23:4], pick_reg());
      end else begin
         return {r[24:0], 7'b0000011};              // load, not supported
      end
   endfunction

   task automatic drive_fetch(input logic [31:0] instr);
      fetch_valid     = 1'b1;
      fetch_pkt.instr = instr;
      fetch_pkt.pc    = pc[31:1];
      pc              = pc + 32'd4;
      sent++;
   endtask

   // called at a falling edge, returns at the falling edge after the transfer
   task automatic send_instr(input logic [31:0] instr);
      drive_fetch(instr);
      while (fetch_ready !== 1'b1) @(negedge clk);
      @(negedge clk);
   endtask

   task automatic wait_drain();
      fetch_valid = 1'b0;
      while (retired != sent) @(negedge clk);
   endtask

   task automatic end_test(input string name);
      int errs;
      errs = chk_errors + tb_errors - err_mark;
      tests_run++;
      if (errs == 0) begin
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: %0d errors", tests_run, name, errs);
      end
      err_mark = chk_errors + tb_errors;
   endtask

   // ******************************
   // test sequence
   // ******************************
   initial begin : run
      int i;
      clk          = 1'b0;
      rst          = 1'b1;
      fetch_valid  = 1'b0;
      fetch_pkt    = '0;
      halt_req     = 1'b0;
      lcg_state    = 32'h5b5773d1;
      pc           = 32'h0000_1000;
      tb_errors    = 0;
      err_mark     = 0;
      tests_run    = 0;
      tests_failed = 0;
      sent         = 0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      for (i = 1; i <= N_INIT; i++) begin
         send_instr(enc_i(12'(lcg_next() >> 20), 5'd0, 3'b000, 5'(i)));   // known values
      end
      for (i = 0; i < N_RAND; i++) begin
         send_instr(rand_instr());
      end
      wait_drain();
      end_test("dependent ALU and immediate stream");

      send_instr(enc_i(12'h055, 5'd0, 3'b000, 5'd0));       // addi x0
      send_instr(enc_r(7'b0, 5'd0, 5'd0, 3'b000, 5'd3));    // reads x0 right after
      send_instr(enc_u(20'habcde, 5'd0));
      send_instr(enc_i(12'h000, 5'd0, 3'b110, 5'd4));
      send_instr(enc_r(7'b0, 5'd0, 5'd0, 3'b110, 5'd5));
      wait_drain();
      end_test("x0 writes");

      send_instr(enc_i(12'h123, 5'd0, 3'b000, 5'd6));
      send_instr(enc_r(7'b0000001, 5'd2, 5'd1, 3'b000, 5'd6));   // mul, illegal
      send_instr(enc_r(7'b0, 5'd0, 5'd6, 3'b000, 5'd7));         // must see 0x123
      send_instr({12'h000, 5'd7, 3'b010, 5'd7, 7'b0000011});     // lw, illegal
      send_instr(enc_i(12'h001, 5'd7, 3'b011, 5'd7));            // sltiu, illegal
      send_instr(enc_r(7'b0, 5'd6, 5'd7, 3'b000, 5'd1));
      wait_drain();
      end_test("illegal encodings");

      halt_req = 1'b1;
      for (i = 0; i < `DEC_IB_DEPTH; i++) begin
         send_instr(rand_instr());
      end
      if (fetch_ready !== 1'b0) begin
         $display("fetch_ready still high after the buffer filled under halt");
         tb_errors++;
      end
      drive_fetch(rand_instr());                   // held while refused
      while (halted !== 1'b1) @(negedge clk);
      repeat (HALT_HOLD) @(negedge clk);
      end_test("halt back-pressure");

      halt_req = 1'b0;
      while (fetch_ready !== 1'b1) @(negedge clk);
      @(negedge clk);
      wait_drain();
      if (retired != accepted || accepted != sent) begin
         $display("retired %0d and accepted %0d differ from sent %0d", retired, accepted, sent);
         tb_errors++;
      end
      if (halted !== 1'b0) begin
         $display("halted still high after halt_req was released");
         tb_errors++;
      end
      end_test("halt release");

      $display("tests %0d, failed %0d, errors %0d, retired %0d", tests_run, tests_failed,
               chk_errors + tb_errors, retired);
      if (chk_errors + tb_errors == 0 && tests_failed == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sources.f
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/dec_pipe_pkg.sv
rtl/dec_ib_ctl.sv
rtl/dec_decode_ctl.sv
rtl/dec_gpr_ctl.sv
rtl/dec_exu_ctl.sv
rtl/dec_top.sv
verification/dec_checker.sv
verification/dec_tb.sv

//--- Makefile
# Verilator lint and simulation of the decode pipeline testbench

VERILATOR ?= verilator
TOP       ?= dec_tb
SEED_ARGS ?=
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  := PASS: all tests

SRCS := $(wildcard rtl/*.sv rtl/*.svh verification/*.sv)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing -f sources.f --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): sources.f $(SRCS)
	$(VERILATOR) $(VFLAGS) -f sources.f --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
